// ==== design/memPkg.sv ====
`default_nettype none

package memPkg;

    localparam int LINE_BITS = 5;              // 32-byte lines.
    localparam int SET_BITS = 2;
    localparam int WAY_BITS = 2;
    localparam int TAG_BITS = 25;
    localparam int WORD_BITS = 3;              // Word offset inside a line.
    localparam int WORDS_PER_LINE = 8;
    localparam int NUM_SETS = 4;
    localparam int NUM_WAYS = 4;
    localparam int NUM_PORTS = 2;              // Load port, then store port.
    localparam int SRAM_WORDS = 128;
    localparam int SRAM_IDX_BITS = 7;
    localparam int LINE_IDX_BITS = WAY_BITS + SET_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set;
        logic [WORD_BITS-1:0] word;
        logic [LINE_BITS-WORD_BITS-1:0] byteOff;
    } AddrFields;

    // Same 32-bit word, either raw or split into cache fields.
    typedef union packed {
        logic [31:0] raw;
        AddrFields f;
    } CacheAddr;

    typedef struct packed {
        logic valid;
        logic isLoad;
        logic isMmio;
        CacheAddr addr;
        logic [SRAM_IDX_BITS-1:0] sramIdx;     // {way, set, word}.
        logic [31:0] storeData;
    } MemOp;

    typedef enum logic [1:0] {
        XFER_NONE,
        XFER_FILL,
        XFER_WRITEBACK
    } XferCmd;

endpackage

`default_nettype wire

// ==== design/memCtrlIf.sv ====
`default_nettype none

interface memCtrlIf import memPkg::*; ();

    XferCmd cmd;                               // One-cycle pulse.
    CacheAddr lineAddr;                        // External line base.
    logic [LINE_IDX_BITS-1:0] sramLine;        // {way, set}.
    logic busy;

    modport controller (
        output cmd,
        output lineAddr,
        output sramLine,
        input busy
    );

    modport copier (
        input cmd,
        input lineAddr,
        input sramLine,
        output busy
    );

endinterface

`default_nettype wire

// ==== design/cacheController.sv ====
`default_nettype none

module cacheController import memPkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic ldValid,
    input wire CacheAddr ldAddr,
    input wire logic stValid,
    input wire CacheAddr stAddr,
    input wire logic [31:0] stData,
    output logic ldStall,
    output logic stStall,
    output MemOp ldOp,
    output MemOp stOp,
    memCtrlIf.controller xfer
);

    logic [TAG_BITS-1:0] tagMem [NUM_SETS][NUM_WAYS];
    logic lineValid [NUM_SETS][NUM_WAYS];
    logic lineDirty [NUM_SETS][NUM_WAYS];
    logic lineUsed [NUM_SETS][NUM_WAYS];       // Most recently hit way.

    logic portValid [NUM_PORTS];
    CacheAddr portAddr [NUM_PORTS];
    logic [SET_BITS-1:0] setIdx [NUM_PORTS];
    logic isMmio [NUM_PORTS];
    logic hit [NUM_PORTS];
    logic [WAY_BITS-1:0] hitWay [NUM_PORTS];
    logic freeAvail [NUM_PORTS];
    logic [WAY_BITS-1:0] freeWay [NUM_PORTS];
    logic [WAY_BITS-1:0] notUsedWay [NUM_PORTS];
    logic [WAY_BITS-1:0] victimWay [NUM_PORTS];
    logic miss [NUM_PORTS];
    logic accept [NUM_PORTS];
    logic cachedHit [NUM_PORTS];
    MemOp nextOp [NUM_PORTS];

    enum logic [1:0] {IDLE, EVICT, FILL} state;

    XferCmd cmdQ;
    CacheAddr lineAddrQ;
    logic [LINE_IDX_BITS-1:0] sramLineQ;
    CacheAddr missAddr;
    logic busyQ;

    logic claim;
    CacheAddr claimAddr;
    logic [SET_BITS-1:0] claimSet;
    logic [WAY_BITS-1:0] claimWay;
    logic victimDirty;
    CacheAddr victimBase;
    CacheAddr missBase;
    logic busyFall;
    logic evictDone;
    logic fillDone;
    logic [WAY_BITS-1:0] fillWay;
    logic [SET_BITS-1:0] fillSet;

    always_comb begin
        portValid[0] = ldValid;
        portAddr[0] = ldAddr;
        portValid[1] = stValid;
        portAddr[1] = stAddr;
        for (int p = 0; p < NUM_PORTS; p++) begin
            setIdx[p] = portAddr[p].f.set;
            isMmio[p] = portAddr[p].raw[31];
            hit[p] = 1'b0;
            hitWay[p] = '0;
            freeAvail[p] = 1'b0;
            freeWay[p] = '0;
            notUsedWay[p] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (lineValid[setIdx[p]][w] && tagMem[setIdx[p]][w] == portAddr[p].f.tag) begin
                    hit[p] = 1'b1;
                    hitWay[p] = w[WAY_BITS-1:0];
                end
                if (!lineValid[setIdx[p]][w]) begin
                    freeAvail[p] = 1'b1;
                    freeWay[p] = w[WAY_BITS-1:0];
                end
                if (!lineUsed[setIdx[p]][w]) begin
                    notUsedWay[p] = w[WAY_BITS-1:0];
                end
            end
            victimWay[p] = freeAvail[p] ? freeWay[p] : notUsedWay[p];
            miss[p] = portValid[p] && !isMmio[p] && !hit[p];
            accept[p] = portValid[p] && !miss[p];
            cachedHit[p] = portValid[p] && !isMmio[p] && hit[p];

            nextOp[p].valid = accept[p];
            nextOp[p].isLoad = (p == 0);
            nextOp[p].isMmio = isMmio[p];
            nextOp[p].addr = portAddr[p];
            nextOp[p].sramIdx = {hitWay[p], setIdx[p], portAddr[p].f.word};
            nextOp[p].storeData = (p == 1) ? stData : '0;
        end
    end

    assign ldStall = miss[0];
    assign stStall = miss[1];

    // Load port wins the transfer FSM.
    always_comb begin
        claim = (state == IDLE) && (miss[0] || miss[1]);
        claimAddr = miss[0] ? portAddr[0] : portAddr[1];
        claimSet = claimAddr.f.set;
        claimWay = miss[0] ? victimWay[0] : victimWay[1];
        // A store hit on the victim in this very cycle makes it dirty.
        victimDirty = lineDirty[claimSet][claimWay] ||
            (miss[0] && cachedHit[1] && setIdx[1] == claimSet && hitWay[1] == claimWay);
        victimBase = '0;
        victimBase.f.tag = tagMem[claimSet][claimWay];
        victimBase.f.set = claimSet;
        missBase = claimAddr;
        missBase.f.word = '0;
        missBase.f.byteOff = '0;
    end

    assign busyFall = busyQ && !xfer.busy;
    assign evictDone = (state == EVICT) && busyFall;
    assign fillDone = (state == FILL) && busyFall;
    assign fillWay = sramLineQ[LINE_IDX_BITS-1:SET_BITS];
    assign fillSet = sramLineQ[SET_BITS-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cmdQ <= XFER_NONE;
            busyQ <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    lineValid[s][w] <= 1'b0;
                    lineDirty[s][w] <= 1'b0;
                    lineUsed[s][w] <= 1'b0;
                end
            end
        end else begin
            busyQ <= xfer.busy;
            cmdQ <= XFER_NONE;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cachedHit[p]) begin
                    for (int w = 0; w < NUM_WAYS; w++) begin
                        lineUsed[setIdx[p]][w] <= 1'b0;
                    end
                    lineUsed[setIdx[p]][hitWay[p]] <= 1'b1;
                end
            end
            if (cachedHit[1]) begin
                lineDirty[setIdx[1]][hitWay[1]] <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (claim) begin
                        lineValid[claimSet][claimWay] <= 1'b0;
                        lineDirty[claimSet][claimWay] <= 1'b0;
                        lineUsed[claimSet][claimWay] <= 1'b0;
                        cmdQ <= victimDirty ? XFER_WRITEBACK : XFER_FILL;
                        state <= victimDirty ? EVICT : FILL;
                    end
                end
                EVICT: begin
                    if (evictDone) begin
                        cmdQ <= XFER_FILL;
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (fillDone) begin
                        lineValid[fillSet][fillWay] <= 1'b1;
                        lineDirty[fillSet][fillWay] <= 1'b0;
                        for (int w = 0; w < NUM_WAYS; w++) begin
                            lineUsed[fillSet][w] <= 1'b0;
                        end
                        lineUsed[fillSet][fillWay] <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (claim) begin
            missAddr <= missBase;
            sramLineQ <= {claimWay, claimSet};
            lineAddrQ <= victimDirty ? victimBase : missBase;
        end else if (evictDone) begin
            lineAddrQ <= missAddr;
        end
        if (fillDone) begin
            tagMem[fillSet][fillWay] <= missAddr.f.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ldOp.valid <= 1'b0;
            stOp.valid <= 1'b0;
        end else begin
            ldOp <= nextOp[0];
            stOp <= nextOp[1];
        end
    end

    assign xfer.cmd = cmdQ;
    assign xfer.lineAddr = lineAddrQ;
    assign xfer.sramLine = sramLineQ;

    cmdOnlyWhenIdle: assert property (@(posedge clk) disable iff (rst)
        xfer.cmd != XFER_NONE |-> !xfer.busy)
        else $error("Transfer command while copier busy.");

    ldStallHolds: assert property (@(posedge clk) disable iff (rst)
        ldStall |=> !ldOp.valid)
        else $error("Stalled load reached the data stage.");

    stStallHolds: assert property (@(posedge clk) disable iff (rst)
        stStall |=> !stOp.valid)
        else $error("Stalled store reached the data stage.");

endmodule

`default_nettype wire

// ==== design/lineCopier.sv ====
`default_nettype none

module lineCopier import memPkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic [31:0] extRData,
    input wire logic [31:0] sramRData,
    output logic extRe,
    output logic extWe,
    output logic [31:0] extAddr,
    output logic [31:0] extWData,
    output logic sramWe,
    output logic [SRAM_IDX_BITS-1:0] sramIdx,
    output logic [31:0] sramWData,
    memCtrlIf.copier xfer
);

    logic busy;
    logic reading;                             // Word phase on the external bus.
    logic isFill;
    logic wrPend;                              // Fill word arriving this cycle.
    logic [WORD_BITS-1:0] cnt;
    logic [WORD_BITS-1:0] wrWord;
    CacheAddr lineQ;
    CacheAddr extAddrC;
    logic [LINE_IDX_BITS-1:0] lineIdxQ;
    logic start;
    logic lastWord;

    assign start = xfer.cmd != XFER_NONE;
    assign lastWord = cnt == WORD_BITS'(WORDS_PER_LINE - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            reading <= 1'b0;
            isFill <= 1'b0;
            wrPend <= 1'b0;
            cnt <= '0;
        end else begin
            wrPend <= reading && isFill;
            if (start) begin
                busy <= 1'b1;
                reading <= 1'b1;
                isFill <= xfer.cmd == XFER_FILL;
                cnt <= '0;
            end else if (reading) begin
                cnt <= cnt + 1'b1;
                if (lastWord) begin
                    reading <= 1'b0;
                    if (!isFill) begin
                        busy <= 1'b0;              // Write-back ends with the last write.
                    end
                end
            end
            if (wrPend && wrWord == WORD_BITS'(WORDS_PER_LINE - 1)) begin
                busy <= 1'b0;                      // Fill ends with the last SRAM write.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            lineQ <= xfer.lineAddr;
            lineIdxQ <= xfer.sramLine;
        end
        wrWord <= cnt;
    end

    always_comb begin
        extAddrC = lineQ;
        extAddrC.f.word = cnt;
        extAddrC.f.byteOff = '0;
    end

    assign extRe = reading && isFill;
    assign extWe = reading && !isFill;
    assign extAddr = extAddrC.raw;
    assign extWData = sramRData;               // SRAM read is combinational.
    assign sramWe = wrPend;
    assign sramIdx = wrPend ? {lineIdxQ, wrWord} : {lineIdxQ, cnt};
    assign sramWData = extRData;
    assign xfer.busy = busy;

    extExclusive: assert property (@(posedge clk) disable iff (rst)
        !(extRe && extWe))
        else $error("External read and write together.");

endmodule

`default_nettype wire

// ==== design/dataStage.sv ====
`default_nettype none

module dataStage import memPkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire MemOp ldOp,
    input wire MemOp stOp,
    input wire logic sramWe,
    input wire logic [SRAM_IDX_BITS-1:0] sramIdx,
    input wire logic [31:0] sramWData,
    output logic [31:0] sramRData,
    output logic ldResValid,
    output logic [31:0] ldResData,
    output logic mmioValid,
    output logic mmioIsLoad,
    output logic [31:0] mmioAddr,
    output logic [31:0] mmioData
);

    logic [31:0] sram [SRAM_WORDS];

    logic ldHit;
    logic stHit;
    logic ldMmio;
    logic stMmio;
    logic pendValid;                           // Store MMIO held back one slot.
    logic [31:0] pendAddr;
    logic [31:0] pendData;
    logic selPend;
    logic loadPend;

    assign ldHit = ldOp.valid && !ldOp.isMmio;
    assign stHit = stOp.valid && !stOp.isMmio;
    assign ldMmio = ldOp.valid && ldOp.isMmio;
    assign stMmio = stOp.valid && stOp.isMmio;

    assign sramRData = sram[sramIdx];

    // Copier write comes last so it wins on the same word.
    always_ff @(posedge clk) begin
        if (stHit) begin
            sram[stOp.sramIdx] <= stOp.storeData;
        end
        if (sramWe) begin
            sram[sramIdx] <= sramWData;
        end
        ldResData <= sram[ldOp.sramIdx];
    end

    // Order on the MMIO port is load, held store, new store.
    assign selPend = !ldMmio && pendValid;
    assign loadPend = stMmio && (ldMmio ? !pendValid : pendValid);

    always_ff @(posedge clk) begin
        if (rst) begin
            ldResValid <= 1'b0;
            mmioValid <= 1'b0;
            pendValid <= 1'b0;
        end else begin
            ldResValid <= ldHit;
            mmioValid <= ldMmio || pendValid || stMmio;
            pendValid <= (ldMmio && (pendValid || stMmio)) || (selPend && stMmio);
        end
    end

    always_ff @(posedge clk) begin
        mmioIsLoad <= ldMmio;
        if (ldMmio) begin
            mmioAddr <= ldOp.addr.raw;
            mmioData <= '0;
        end else if (pendValid) begin
            mmioAddr <= pendAddr;
            mmioData <= pendData;
        end else begin
            mmioAddr <= stOp.addr.raw;
            mmioData <= stOp.storeData;
        end
        if (loadPend) begin
            pendAddr <= stOp.addr.raw;
            pendData <= stOp.storeData;
        end
    end

endmodule

`default_nettype wire

// ==== design/memSubsystem.sv ====
`default_nettype none

module memSubsystem import memPkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic ldValid,
    input wire logic [31:0] ldAddr,
    input wire logic stValid,
    input wire logic [31:0] stAddr,
    input wire logic [31:0] stData,
    output logic ldStall,
    output logic stStall,
    output logic ldResValid,
    output logic [31:0] ldResData,
    output logic mmioValid,
    output logic mmioIsLoad,
    output logic [31:0] mmioAddr,
    output logic [31:0] mmioData,
    output logic extRe,
    output logic extWe,
    output logic [31:0] extAddr,
    output logic [31:0] extWData,
    input wire logic [31:0] extRData
);

    wire MemOp ldOp;
    wire MemOp stOp;
    wire sramWe;
    wire [SRAM_IDX_BITS-1:0] sramIdx;
    wire [31:0] sramWData;
    wire [31:0] sramRData;

    memCtrlIf xferIf ();

    cacheController i_cacheController (
        .clk(clk),
        .rst(rst),
        .ldValid(ldValid),
        .ldAddr(ldAddr),
        .stValid(stValid),
        .stAddr(stAddr),
        .stData(stData),
        .ldStall(ldStall),
        .stStall(stStall),
        .ldOp(ldOp),
        .stOp(stOp),
        .xfer(xferIf.controller)
    );

    lineCopier i_lineCopier (
        .clk(clk),
        .rst(rst),
        .extRData(extRData),
        .sramRData(sramRData),
        .extRe(extRe),
        .extWe(extWe),
        .extAddr(extAddr),
        .extWData(extWData),
        .sramWe(sramWe),
        .sramIdx(sramIdx),
        .sramWData(sramWData),
        .xfer(xferIf.copier)
    );

    dataStage i_dataStage (
        .clk(clk),
        .rst(rst),
        .ldOp(ldOp),
        .stOp(stOp),
        .sramWe(sramWe),
        .sramIdx(sramIdx),
        .sramWData(sramWData),
        .sramRData(sramRData),
        .ldResValid(ldResValid),
        .ldResData(ldResData),
        .mmioValid(mmioValid),
        .mmioIsLoad(mmioIsLoad),
        .mmioAddr(mmioAddr),
        .mmioData(mmioData)
    );

endmodule

`default_nettype wire

// ==== verif/memSubsystemTb.sv ====
`default_nettype none

module memSubsystemTb import memPkg::*; ();

    localparam int STALL_LIMIT = 200;
    localparam int RESULT_LIMIT = 10;

    typedef struct packed {
        logic isStore;
        CacheAddr addr;
        logic [31:0] data;
        logic expStall;
        logic [3:0] expWb;                     // Write-back words expected.
        CacheAddr wbLine;
        logic [2:0] testId;
    } Entry;

    logic clk;
    logic rst;
    logic ldValid;
    logic [31:0] ldAddr;
    logic stValid;
    logic [31:0] stAddr;
    logic [31:0] stData;
    logic ldStall;
    logic stStall;
    logic ldResValid;
    logic [31:0] ldResData;
    logic mmioValid;
    logic mmioIsLoad;
    logic [31:0] mmioAddr;
    logic [31:0] mmioData;
    logic extRe;
    logic extWe;
    logic [31:0] extAddr;
    logic [31:0] extWData;
    logic [31:0] extRData;

    logic [31:0] extMem [logic [29:0]];
    logic [31:0] shadow [logic [29:0]];
    logic rdPend;
    logic [31:0] rdWord;
    CacheAddr wbLine;
    int wbSeen;
    int errors;
    int checks;
    logic timedOut;
    int seed;
    Entry stim [$];

    memSubsystem i_memSubsystem (
        .clk(clk),
        .rst(rst),
        .ldValid(ldValid),
        .ldAddr(ldAddr),
        .stValid(stValid),
        .stAddr(stAddr),
        .stData(stData),
        .ldStall(ldStall),
        .stStall(stStall),
        .ldResValid(ldResValid),
        .ldResData(ldResData),
        .mmioValid(mmioValid),
        .mmioIsLoad(mmioIsLoad),
        .mmioAddr(mmioAddr),
        .mmioData(mmioData),
        .extRe(extRe),
        .extWe(extWe),
        .extAddr(extAddr),
        .extWData(extWData),
        .extRData(extRData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] patternWord(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] shadowWord(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return patternWord(addr);
    endfunction

    function automatic logic [31:0] extRead(input logic [31:0] addr);
        if (extMem.exists(addr[31:2])) begin
            return extMem[addr[31:2]];
        end
        return patternWord(addr);
    endfunction

    function automatic string testName(input logic [2:0] id);
        case (id)
            3'd1: return "cold line load";
            3'd2: return "store then load";
            3'd3: return "set eviction";
            3'd4: return "reload of evicted line";
            default: return "mmio bypass";
        endcase
    endfunction

    task automatic checkLoad(input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t ldResData got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic checkStall(input logic isStore, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %b expected %b",
                     $time, isStore ? "stStall" : "ldStall", got, exp);
        end
    endtask

    task automatic checkMmio(input logic gotLoad, input logic [31:0] gotAddr,
                             input logic [31:0] gotData, input Entry e);
        checks++;
        if (gotLoad !== !e.isStore) begin
            errors++;
            $display("CHECK FAILED t=%0t mmioIsLoad got %b expected %b",
                     $time, gotLoad, !e.isStore);
        end
        if (gotAddr !== e.addr.raw) begin
            errors++;
            $display("CHECK FAILED t=%0t mmioAddr got %h expected %h", $time, gotAddr, e.addr.raw);
        end
        if (e.isStore && gotData !== e.data) begin
            errors++;
            $display("CHECK FAILED t=%0t mmioData got %h expected %h", $time, gotData, e.data);
        end
    endtask

    task automatic checkWb(input CacheAddr addr, input logic [31:0] data);
        checks++;
        if (addr.f.tag !== wbLine.f.tag || addr.f.set !== wbLine.f.set) begin
            errors++;
            $display("CHECK FAILED t=%0t extAddr got %h expected line %h",
                     $time, addr.raw, wbLine.raw);
        end
        if (data !== shadowWord(addr.raw)) begin
            errors++;
            $display("CHECK FAILED t=%0t extWData got %h expected %h",
                     $time, data, shadowWord(addr.raw));
        end
    endtask

    task automatic checkWbCount(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED t=%0t extWe word count got %0d expected %0d",
                     $time, got, exp);
        end
    endtask

    // External memory model with read data one cycle after extRe.
    always @(negedge clk) begin
        rdPend = extRe;
        if (extRe) begin
            rdWord = extRead(extAddr);
        end
        if (extWe) begin
            checkWb(extAddr, extWData);
            extMem[extAddr[31:2]] = extWData;
            wbSeen++;
        end
    end

    always @(posedge clk) begin
        #1;
        if (rdPend) begin
            extRData = rdWord;
        end
    end

    task automatic addEntry(input logic isStore, input logic [31:0] addr, input logic [31:0] data,
                            input logic expStall, input logic [3:0] expWb,
                            input logic [31:0] line, input logic [2:0] testId);
        Entry e;
        e.isStore = isStore;
        e.addr.raw = addr;
        e.data = data;
        e.expStall = expStall;
        e.expWb = expWb;
        e.wbLine.raw = line;
        e.testId = testId;
        stim.push_back(e);
    endtask

    // Set 0 fills ways 3, 2, 1, 0; line 0x100 is the dirty victim.
    task automatic buildTable();
        addEntry(1'b0, 32'h0000_0040, 32'h0, 1'b1, 4'd0, 32'h0, 3'd1);
        addEntry(1'b1, 32'h0000_0104, $random(seed), 1'b1, 4'd0, 32'h0, 3'd2);
        addEntry(1'b0, 32'h0000_0104, 32'h0, 1'b0, 4'd0, 32'h0, 3'd2);
        addEntry(1'b1, 32'h0000_0048, $random(seed), 1'b0, 4'd0, 32'h0, 3'd2);
        addEntry(1'b0, 32'h0000_0048, 32'h0, 1'b0, 4'd0, 32'h0, 3'd2);
        addEntry(1'b0, 32'h0000_0000, 32'h0, 1'b1, 4'd0, 32'h0, 3'd3);
        addEntry(1'b0, 32'h0000_0080, 32'h0, 1'b1, 4'd0, 32'h0, 3'd3);
        addEntry(1'b0, 32'h0000_0180, 32'h0, 1'b1, 4'd0, 32'h0, 3'd3);
        addEntry(1'b0, 32'h0000_0200, 32'h0, 1'b1, 4'd8, 32'h0000_0100, 3'd3);
        addEntry(1'b0, 32'h0000_0284, 32'h0, 1'b1, 4'd0, 32'h0, 3'd3);  // Clean victim.
        addEntry(1'b0, 32'h0000_0104, 32'h0, 1'b1, 4'd0, 32'h0, 3'd4);
        addEntry(1'b0, 32'h8000_0010, 32'h0, 1'b0, 4'd0, 32'h0, 3'd5);
        addEntry(1'b1, 32'h8000_0020, $random(seed), 1'b0, 4'd0, 32'h0, 3'd5);
    endtask

    task automatic acceptEntry(input Entry e, output logic stalled, output logic ok);
        int cycles;
        logic stall;
        stalled = 1'b0;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < STALL_LIMIT) begin
            @(negedge clk);
            stall = e.isStore ? stStall : ldStall;
            if (!stall) begin
                ok = 1'b1;
            end else begin
                stalled = 1'b1;
                cycles++;
            end
        end
    endtask

    task automatic waitResult(input Entry e, output logic ok);
        int cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        ok = 1'b1;
        if (e.addr.raw[31] || !e.isStore) begin
            while (!seen && cycles < RESULT_LIMIT) begin
                @(negedge clk);
                seen = e.addr.raw[31] ? mmioValid : ldResValid;
                cycles++;
            end
            ok = seen;
            if (seen && e.addr.raw[31]) begin
                checkMmio(mmioIsLoad, mmioAddr, mmioData, e);
            end else if (seen) begin
                checkLoad(ldResData, shadowWord(e.addr.raw));
            end
        end
    endtask

    task automatic applyEntry(input Entry e);
        logic stalled;
        logic ok;
        @(posedge clk);
        #1;
        wbLine = e.wbLine;
        wbSeen = 0;
        ldValid = !e.isStore;
        ldAddr = e.addr.raw;
        stValid = e.isStore;
        stAddr = e.addr.raw;
        stData = e.data;
        acceptEntry(e, stalled, ok);
        if (!ok) begin
            timedOut = 1'b1;
            errors++;
            $display("Timeout: access to %h still stalled after %0d cycles",
                     e.addr.raw, STALL_LIMIT);
        end else begin
            @(posedge clk);
            #1;
            ldValid = 1'b0;
            stValid = 1'b0;
            if (e.isStore && !e.addr.raw[31]) begin
                shadow[e.addr.raw[31:2]] = e.data;
            end
            checkStall(e.isStore, stalled, e.expStall);
            waitResult(e, ok);
            if (!ok) begin
                timedOut = 1'b1;
                errors++;
                $display("Timeout: no result for access to %h", e.addr.raw);
            end
            checkWbCount(wbSeen, int'(e.expWb));
        end
    endtask

    initial begin
        int testErr;
        rst = 1'b1;
        ldValid = 1'b0;
        ldAddr = '0;
        stValid = 1'b0;
        stAddr = '0;
        stData = '0;
        extRData = '0;
        rdPend = 1'b0;
        rdWord = '0;
        wbLine = '0;
        wbSeen = 0;
        errors = 0;
        checks = 0;
        timedOut = 1'b0;
        seed = 32'ha7988698;
        buildTable();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        testErr = 0;
        for (int i = 0; i < stim.size() && !timedOut; i++) begin
            applyEntry(stim[i]);
            if (i == stim.size() - 1 || stim[i + 1].testId != stim[i].testId) begin
                $display("Test %0d (%s) done, %0d errors",
                         stim[i].testId, testName(stim[i].testId), errors - testErr);
                testErr = errors;
            end
        end
        $display("Checks run: %0d, failed: %0d", checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
design/memPkg.sv
design/memCtrlIf.sv
design/cacheController.sv
design/lineCopier.sv
design/dataStage.sv
design/memSubsystem.sv
verif/memSubsystemTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = memSubsystemTb
FLIST = flist.f
BUILD = obj_dir
PASS_TEXT = Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD)
